/* build.f */
+incdir+.
riscv_pkg.sv
control_unit.sv
imm_ext.sv
reg_file.sv
pipe_reg.sv
decode.sv
decode_top.sv
tb_clock_gen.sv
tb_decode_top.sv

/* Bender.yml */
package:
  name: riscv_decode

export_include_dirs:
  - .

sources:
  - files:
      - riscv_pkg.sv
      - control_unit.sv
      - imm_ext.sv
      - reg_file.sv
      - pipe_reg.sv
      - decode.sv
      - decode_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_decode_top.sv

/* tb_decode_top.sv */
// Testbench for decode_top with stimulus, reference model, comparator and timeout
`timescale 1ns/1ps
`default_nettype none

`include "riscv_defines.svh"

module tb_decode_top;
    import riscv_pkg::*;

    // Directed part is under 150 cycles, random part about 400
    localparam int MAX_CYCLES = 2000;
    localparam int NUM_RANDOM = 300;

    logic clk;
    logic rst_n;
    logic stall;
    logic flush;
    fd_t  fd_in;
    wb_t  wb;
    de_t  de_out;

    logic [`XLEN-1:0] shadow [32];
    logic [6:0]       ops [10];
    logic [`XLEN-1:0] next_pc = 32'h0000_1000;
    fd_t              exp_fd;
    de_t              exp_de;
    integer           seed = 55945;
    int               cycles = 0;
    int               error_count = 0;

    tb_clock_gen clk_gen (
        .clk (clk)
    );

    decode_top uut (
        .clk    (clk),
        .rst_n  (rst_n),
        .stall  (stall),
        .flush  (flush),
        .fd_in  (fd_in),
        .wb     (wb),
        .de_out (de_out)
    );

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            error_count++;
            $display("error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            $display("CHECKS FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////

    // Decode of one fetch word against the shadow registers
    function automatic de_t expect_decode(input fd_t f);
        de_t         e;
        logic [31:0] i;
        logic [6:0]  op;
        alu_op_e     alu;
        i  = f.instr;
        op = i[6:0];
        e  = '0;
        case (i[14:12])
            3'b000:  alu = (op == `OP_R && i[30]) ? ALU_SUB : ALU_ADD;
            3'b001:  alu = ALU_SLL;
            3'b010:  alu = ALU_SLT;
            3'b011:  alu = ALU_SLTU;
            3'b100:  alu = ALU_XOR;
            3'b101:  alu = i[30] ? ALU_SRA : ALU_SRL;
            3'b110:  alu = ALU_OR;
            default: alu = ALU_AND;
        endcase
        e.imm_val = {{20{i[31]}}, i[31:20]};
        case (op)
            `OP_R: begin
                e.ctrl.reg_write   = 1'b1;
                e.ctrl.alu_control = alu;
            end
            `OP_I: begin
                e.ctrl.reg_write   = 1'b1;
                e.ctrl.alu_control = alu;
                e.ctrl.alu_src_b   = 1'b1;
            end
            `OP_LOAD: begin
                e.ctrl.reg_write = 1'b1;
                e.ctrl.res_src   = 2'b01;
                e.ctrl.alu_src_b = 1'b1;
            end
            `OP_STORE: begin
                e.ctrl.mem_write = 1'b1;
                e.ctrl.alu_src_b = 1'b1;
                e.imm_val        = {{20{i[31]}}, i[31:25], i[11:7]};
            end
            `OP_BRANCH: begin
                e.ctrl.branch      = 1'b1;
                e.ctrl.alu_control = ALU_SUB;
                e.imm_val          = {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
            end
            `OP_JAL: begin
                e.ctrl.reg_write = 1'b1;
                e.ctrl.res_src   = 2'b10;
                e.ctrl.jump      = 1'b1;
                e.imm_val        = {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
            end
            `OP_JALR: begin
                e.ctrl.reg_write = 1'b1;
                e.ctrl.res_src   = 2'b10;
                e.ctrl.jump      = 1'b1;
                e.ctrl.alu_src_b = 1'b1;
                e.ctrl.adder_src = 1'b1;
            end
            `OP_LUI: begin
                e.ctrl.reg_write   = 1'b1;
                e.ctrl.alu_control = ALU_PASS_B;
                e.ctrl.alu_src_b   = 1'b1;
                e.imm_val          = {i[31:12], 12'b0};
            end
            `OP_AUIPC: begin
                e.ctrl.reg_write = 1'b1;
                e.ctrl.alu_src_a = 1'b1;
                e.ctrl.alu_src_b = 1'b1;
                e.imm_val        = {i[31:12], 12'b0};
            end
            default: begin
                e.ctrl = '0;
            end
        endcase
        if (!f.valid) begin
            e.ctrl = '0;
        end
        e.valid    = f.valid;
        e.funct3   = i[14:12];
        e.rs1      = i[19:15];
        e.rs2      = i[24:20];
        e.rd       = i[11:7];
        e.rd1      = (e.rs1 == 0) ? '0 : shadow[e.rs1];
        e.rd2      = (e.rs2 == 0) ? '0 : shadow[e.rs2];
        e.pc       = f.pc;
        e.pc_plus4 = f.pc_plus4;
        return e;
    endfunction

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < 32; r++) begin
                shadow[r] = '0;
            end
            exp_fd = '0;
            exp_de = '0;
        end else begin
            // Writes land under stall too and are seen by the same-cycle read
            if (wb.reg_write && wb.rd != 0) begin
                shadow[wb.rd] = wb.result;
            end
            if (!stall) begin
                exp_de = flush ? de_t'('0) : expect_decode(exp_fd);
                exp_fd = flush ? fd_t'('0) : fd_in;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Comparator and timeout
    ////////////////////////////////////////////////////////////////////////

    task automatic compare_output();
        check_value("de_out.valid", de_out.valid, exp_de.valid);
        check_value("de_out.ctrl", de_out.ctrl, exp_de.ctrl);
        check_value("de_out.funct3", de_out.funct3, exp_de.funct3);
        check_value("de_out.rd1", de_out.rd1, exp_de.rd1);
        check_value("de_out.rd2", de_out.rd2, exp_de.rd2);
        check_value("de_out.pc", de_out.pc, exp_de.pc);
        check_value("de_out.rs1", de_out.rs1, exp_de.rs1);
        check_value("de_out.rs2", de_out.rs2, exp_de.rs2);
        check_value("de_out.rd", de_out.rd, exp_de.rd);
        check_value("de_out.imm_val", de_out.imm_val, exp_de.imm_val);
        check_value("de_out.pc_plus4", de_out.pc_plus4, exp_de.pc_plus4);
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            compare_output();
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: test did not finish within %0d cycles", MAX_CYCLES);
            $display("CHECKS FAILED");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////

    task automatic drive(input fd_t f, input logic s, input logic fl, input wb_t w);
        @(negedge clk);
        fd_in = f;
        stall = s;
        flush = fl;
        wb    = w;
    endtask

    // Random fields around a fixed opcode, consecutive pc values
    task automatic make_item(input logic [6:0] op, output fd_t f);
        f.valid      = 1'b1;
        f.instr      = $random(seed);
        f.instr[6:0] = op;
        f.pc         = next_pc;
        f.pc_plus4   = next_pc + 4;
        next_pc      = next_pc + 4;
    endtask

    initial begin
        fd_t  f;
        wb_t  w;
        int   sent;
        logic s;
        logic fl;
        ops = '{`OP_R, `OP_I, `OP_LOAD, `OP_STORE, `OP_BRANCH,
                `OP_JAL, `OP_JALR, `OP_LUI, `OP_AUIPC, 7'b1111111};
        rst_n = 1'b0;
        stall = 1'b0;
        flush = 1'b0;
        fd_in = '0;
        wb    = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Bubble at the output after reset
        @(negedge clk);
        check_value("de_out.valid", de_out.valid, 1'b0);
        check_value("de_out.ctrl.reg_write", de_out.ctrl.reg_write, 1'b0);
        check_value("de_out.ctrl.mem_write", de_out.ctrl.mem_write, 1'b0);
        check_value("de_out.ctrl.jump", de_out.ctrl.jump, 1'b0);
        check_value("de_out.ctrl.branch", de_out.ctrl.branch, 1'b0);

        // One of every type, then an unknown opcode
        for (int k = 0; k < 10; k++) begin
            make_item(ops[k], f);
            drive(f, 1'b0, 1'b0, '0);
        end

        // Empty slot carrying a real jump word
        make_item(`OP_JAL, f);
        f.valid = 1'b0;
        drive(f, 1'b0, 1'b0, '0);
        repeat (2) drive('0, 1'b0, 1'b0, '0);

        // Seed every register, x0 included
        for (int r = 0; r < 32; r++) begin
            w.reg_write = 1'b1;
            w.rd        = r[4:0];
            w.result    = $random(seed);
            drive('0, 1'b0, 1'b0, w);
        end
        for (int r = 0; r < 32; r++) begin
            make_item(`OP_R, f);
            f.instr[19:15] = r[4:0];
            f.instr[24:20] = 5'd31 - r[4:0];
            drive(f, 1'b0, 1'b0, '0);
        end

        // x9 written while the reader sits in decode
        make_item(`OP_R, f);
        f.instr[19:15] = 5'd9;
        f.instr[24:20] = 5'd9;
        drive(f, 1'b0, 1'b0, '0);
        w.reg_write = 1'b1;
        w.rd        = 5'd9;
        w.result    = 32'hcafe_0009;
        drive('0, 1'b0, 1'b0, w);

        // x0 written in the read cycle still reads zero
        make_item(`OP_I, f);
        f.instr[19:15] = 5'd0;
        f.instr[24:20] = 5'd0;
        drive(f, 1'b0, 1'b0, '0);
        w.rd     = 5'd0;
        w.result = 32'hffff_ffff;
        drive('0, 1'b0, 1'b0, w);
        repeat (2) drive('0, 1'b0, 1'b0, '0);

        // Stall for four cycles while the source holds its item
        for (int k = 0; k < 3; k++) begin
            make_item(ops[k], f);
            drive(f, 1'b0, 1'b0, '0);
        end
        make_item(`OP_LOAD, f);
        repeat (3) drive(f, 1'b1, 1'b0, '0);
        // Flush during stall must not clear the held items
        drive(f, 1'b1, 1'b1, '0);
        drive(f, 1'b0, 1'b0, '0);
        for (int k = 3; k < 6; k++) begin
            make_item(ops[k], f);
            drive(f, 1'b0, 1'b0, '0);
        end
        repeat (2) drive('0, 1'b0, 1'b0, '0);

        // Flush with two items in flight
        for (int k = 0; k < 2; k++) begin
            make_item(ops[k + 4], f);
            drive(f, 1'b0, 1'b0, '0);
        end
        make_item(`OP_JAL, f);
        drive(f, 1'b0, 1'b1, '0);
        for (int k = 0; k < 3; k++) begin
            make_item(ops[k + 6], f);
            drive(f, 1'b0, 1'b0, '0);
        end
        repeat (2) drive('0, 1'b0, 1'b0, '0);

        // Random mix of items, writebacks, stalls and flushes
        sent = 0;
        f    = '0;
        while (sent < NUM_RANDOM) begin
            s           = (($random(seed) & 7) == 0);
            fl          = (($random(seed) & 15) == 0);
            w.reg_write = $random(seed);
            w.rd        = $random(seed);
            w.result    = $random(seed);
            if (!s) begin
                make_item(ops[$unsigned($random(seed)) % 9], f);
                sent++;
            end
            drive(f, s, fl, w);
        end
        repeat (3) drive('0, 1'b0, 1'b0, '0);
        @(negedge clk);

        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
// Free-running testbench clock with a 20 ns period
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk
);

    localparam real HALF_PERIOD = 10.0;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

endmodule

`default_nettype wire

/* decode_top.sv */
// Decode stage top with fetch/decode and decode/execute pipeline registers
`timescale 1ns/1ps
`default_nettype none

module decode_top (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           stall,
    input  logic           flush,
    input  riscv_pkg::fd_t fd_in,
    input  riscv_pkg::wb_t wb,
    output riscv_pkg::de_t de_out
);
    import riscv_pkg::*;

    fd_t fd_q;
    de_t de_d;

    //////////////////////////////////////////////////////////////////////
    // Fetch/decode boundary
    //////////////////////////////////////////////////////////////////////

    pipe_reg #(
        .payload_t (fd_t)
    ) fd_reg (
        .clk   (clk),
        .rst_n (rst_n),
        .stall (stall),
        .flush (flush),
        .d     (fd_in),
        .q     (fd_q)
    );

    decode u_decode (
        .clk   (clk),
        .rst_n (rst_n),
        .fd    (fd_q),
        .wb    (wb),
        .de    (de_d)
    );

    //////////////////////////////////////////////////////////////////////
    // Decode/execute boundary
    //////////////////////////////////////////////////////////////////////

    pipe_reg #(
        .payload_t (de_t)
    ) de_reg (
        .clk   (clk),
        .rst_n (rst_n),
        .stall (stall),
        .flush (flush),
        .d     (de_d),
        .q     (de_out)
    );

endmodule

`default_nettype wire

/* decode.sv */
// Combinational decode stage joining control unit, register file and immediate unit
`timescale 1ns/1ps
`default_nettype none

`include "riscv_defines.svh"

module decode (
    input  logic           clk,
    input  logic           rst_n,
    input  riscv_pkg::fd_t fd,
    input  riscv_pkg::wb_t wb,
    output riscv_pkg::de_t de
);
    import riscv_pkg::*;

    ctrl_t            ctrl;
    imm_type_e        imm_src;
    logic [`XLEN-1:0] rd1;
    logic [`XLEN-1:0] rd2;
    logic [`XLEN-1:0] imm_val;

    control_unit cu (
        .op      (fd.instr[6:0]),
        .funct3  (fd.instr[14:12]),
        .funct7  (fd.instr[31:25]),
        .ctrl    (ctrl),
        .imm_src (imm_src)
    );

    reg_file rf (
        .clk   (clk),
        .rst_n (rst_n),
        .wb    (wb),
        .a1    (fd.instr[19:15]),
        .a2    (fd.instr[24:20]),
        .rd1   (rd1),
        .rd2   (rd2)
    );

    imm_ext imex (
        .instr    (fd.instr[31:7]),
        .imm_type (imm_src),
        .imm_val  (imm_val)
    );

    always_comb begin
        de.valid    = fd.valid;
        // Empty slot carries no side effects downstream
        de.ctrl     = fd.valid ? ctrl : ctrl_t'('0);
        de.funct3   = fd.instr[14:12];
        de.rd1      = rd1;
        de.rd2      = rd2;
        de.pc       = fd.pc;
        de.rs1      = fd.instr[19:15];
        de.rs2      = fd.instr[24:20];
        de.rd       = fd.instr[11:7];
        de.imm_val  = imm_val;
        de.pc_plus4 = fd.pc_plus4;
    end

endmodule

`default_nettype wire

/* pipe_reg.sv */
// Stage-boundary pipeline register with stall hold and flush to bubble
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     stall,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    // Stall wins over flush, an all-zero payload is the bubble
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q <= '0;
        end else if (!stall) begin
            if (flush) begin
                q <= '0;
            end else begin
                q <= d;
            end
        end
    end

endmodule

`default_nettype wire

/* reg_file.sv */
// 32 x 32 register file, two read ports, one write port, write-through, x0 hardwired
`timescale 1ns/1ps
`default_nettype none

`include "riscv_defines.svh"

module reg_file (
    input  logic                    clk,
    input  logic                    rst_n,
    input  riscv_pkg::wb_t          wb,
    input  logic [`REG_ADDR_W-1:0]  a1,
    input  logic [`REG_ADDR_W-1:0]  a2,
    output logic [`XLEN-1:0]        rd1,
    output logic [`XLEN-1:0]        rd2
);
    import riscv_pkg::*;

    logic [`XLEN-1:0] regs [2**`REG_ADDR_W];

    // Writes to x0 are dropped
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**`REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.reg_write && wb.rd != '0) begin
            regs[wb.rd] <= wb.result;
        end
    end

    // Same-cycle write is forwarded to the reader
    function automatic logic [`XLEN-1:0] read_port(input logic [`REG_ADDR_W-1:0] addr);
        if (addr == '0) begin
            return '0;
        end else if (wb.reg_write && wb.rd == addr) begin
            return wb.result;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rd1 = read_port(a1);
        rd2 = read_port(a2);
    end

endmodule

`default_nettype wire

/* imm_ext.sv */
// Immediate extraction and sign extension for the I, S, B, U and J formats
`timescale 1ns/1ps
`default_nettype none

`include "riscv_defines.svh"

module imm_ext (
    input  logic [`XLEN-1:7]      instr,
    input  riscv_pkg::imm_type_e  imm_type,
    output logic [`XLEN-1:0]      imm_val
);
    import riscv_pkg::*;

    // Bit indices below are the instruction's own bit positions
    always_comb begin
        case (imm_type)
            IMM_S: begin
                imm_val = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            IMM_B: begin
                imm_val = {{20{instr[31]}}, instr[7], instr[30:25],
                           instr[11:8], 1'b0};
            end
            // Upper immediate, low twelve bits zero
            IMM_U: begin
                imm_val = {instr[31:12], 12'b0};
            end
            IMM_J: begin
                imm_val = {{12{instr[31]}}, instr[19:12], instr[20],
                           instr[30:21], 1'b0};
            end
            default: begin
                imm_val = {{20{instr[31]}}, instr[31:20]};
            end
        endcase
    end

endmodule

`default_nettype wire

/* control_unit.sv */
// RV32I main decoder and ALU decoder producing the control word and immediate type
`timescale 1ns/1ps
`default_nettype none

`include "riscv_defines.svh"

module control_unit (
    input  logic [6:0]           op,
    input  logic [2:0]           funct3,
    input  logic [6:0]           funct7,
    output riscv_pkg::ctrl_t     ctrl,
    output riscv_pkg::imm_type_e imm_src
);
    import riscv_pkg::*;

    alu_op_e alu_sel;

    //////////////////////////////////////////////////////////////////////
    // ALU decoder
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (funct3)
            // addi has no sub form, only R-type looks at funct7 here
            `F3_ADD_SUB: begin
                if (op == `OP_R && funct7[`F7_ALT_BIT]) begin
                    alu_sel = ALU_SUB;
                end else begin
                    alu_sel = ALU_ADD;
                end
            end
            `F3_SLL:     alu_sel = ALU_SLL;
            `F3_SLT:     alu_sel = ALU_SLT;
            `F3_SLTU:    alu_sel = ALU_SLTU;
            `F3_XOR:     alu_sel = ALU_XOR;
            `F3_SRL_SRA: alu_sel = funct7[`F7_ALT_BIT] ? ALU_SRA : ALU_SRL;
            `F3_OR:      alu_sel = ALU_OR;
            default:     alu_sel = ALU_AND;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Main decoder
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        // Bubble unless the opcode is recognised
        ctrl    = '0;
        imm_src = IMM_I;
        case (op)
            `OP_R: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_control = alu_sel;
            end
            `OP_I: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_control = alu_sel;
                ctrl.alu_src_b   = 1'b1;
            end
            `OP_LOAD: begin
                ctrl.reg_write = 1'b1;
                ctrl.res_src   = `RES_MEM;
                ctrl.alu_src_b = 1'b1;
            end
            `OP_STORE: begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src_b = 1'b1;
                imm_src        = IMM_S;
            end
            `OP_BRANCH: begin
                // Compare by subtraction, target from pc + imm
                ctrl.branch      = 1'b1;
                ctrl.alu_control = ALU_SUB;
                imm_src          = IMM_B;
            end
            `OP_JAL: begin
                ctrl.reg_write = 1'b1;
                ctrl.res_src   = `RES_PC4;
                ctrl.jump      = 1'b1;
                imm_src        = IMM_J;
            end
            `OP_JALR: begin
                ctrl.reg_write = 1'b1;
                ctrl.res_src   = `RES_PC4;
                ctrl.jump      = 1'b1;
                ctrl.alu_src_b = 1'b1;
                ctrl.adder_src = 1'b1;
            end
            `OP_LUI: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_control = ALU_PASS_B;
                ctrl.alu_src_b   = 1'b1;
                imm_src          = IMM_U;
            end
            `OP_AUIPC: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src_a = 1'b1;
                ctrl.alu_src_b = 1'b1;
                imm_src        = IMM_U;
            end
            default: begin
                ctrl    = '0;
                imm_src = IMM_I;
            end
        endcase
    end

endmodule

`default_nettype wire

/* riscv_pkg.sv */
// Control, fetch, decode and writeback payload types with the immediate and ALU enums
`default_nettype none

`include "riscv_defines.svh"

package riscv_pkg;

    //////////////////////////////////////////////////////////////////////
    // Enums
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        IMM_I = 3'd0,
        IMM_S = 3'd1,
        IMM_B = 3'd2,
        IMM_U = 3'd3,
        IMM_J = 3'd4
    } imm_type_e;

    // ALU_ADD is zero so that an all-zero control word is a bubble
    typedef enum logic [5:0] {
        ALU_ADD    = 6'd0,
        ALU_SUB    = 6'd1,
        ALU_SLL    = 6'd2,
        ALU_SLT    = 6'd3,
        ALU_SLTU   = 6'd4,
        ALU_XOR    = 6'd5,
        ALU_SRL    = 6'd6,
        ALU_SRA    = 6'd7,
        ALU_OR     = 6'd8,
        ALU_AND    = 6'd9,
        ALU_PASS_B = 6'd10
    } alu_op_e;

    //////////////////////////////////////////////////////////////////////
    // Payload structs
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic       reg_write;
        logic [1:0] res_src;      // ALU, memory or pc+4
        logic       mem_write;
        logic       jump;
        logic       branch;
        alu_op_e    alu_control;
        logic       alu_src_a;    // 0 rs1, 1 pc
        logic       alu_src_b;    // 0 rs2, 1 immediate
        logic       adder_src;    // Jump base, 0 pc, 1 rs1
    } ctrl_t;

    typedef struct packed {
        logic              valid;
        logic [`XLEN-1:0]  instr;
        logic [`XLEN-1:0]  pc;
        logic [`XLEN-1:0]  pc_plus4;
    } fd_t;

    typedef struct packed {
        logic                   valid;
        ctrl_t                  ctrl;
        logic [2:0]             funct3;
        logic [`XLEN-1:0]       rd1;
        logic [`XLEN-1:0]       rd2;
        logic [`XLEN-1:0]       pc;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       imm_val;
        logic [`XLEN-1:0]       pc_plus4;
    } de_t;

    typedef struct packed {
        logic                   reg_write;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       result;
    } wb_t;

endpackage

`default_nettype wire

/* riscv_defines.svh */
// RV32I widths, opcode values, funct codes and result-source selects
`ifndef RISCV_DEFINES_SVH
`define RISCV_DEFINES_SVH

// Widths
`define XLEN        32
`define REG_ADDR_W  5

// Base opcodes, instruction bits 6:0
`define OP_R        7'b0110011
`define OP_I        7'b0010011
`define OP_LOAD     7'b0000011
`define OP_STORE    7'b0100011
`define OP_BRANCH   7'b1100011
`define OP_JAL      7'b1101111
`define OP_JALR     7'b1100111
`define OP_LUI      7'b0110111
`define OP_AUIPC    7'b0010111

// funct3 for register and immediate arithmetic
`define F3_ADD_SUB  3'b000
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SRL_SRA  3'b101
`define F3_OR       3'b110
`define F3_AND      3'b111

// funct7 bit that selects sub and sra
`define F7_ALT_BIT  5

// Writeback result source
`define RES_ALU     2'b00
`define RES_MEM     2'b01
`define RES_PC4     2'b10

`endif
